// File: verilog/ex_pkg.sv
// Shared widths and operation encoding for the execute stage, imported by every unit and the testbench
package ex_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------

  // Integer register width
  localparam int unsigned XLEN = 32;

  // Scoreboard transaction id
  localparam int unsigned TRANS_ID_BITS = 3;

  // CSR address field of the instruction
  localparam int unsigned CSR_ADDR_BITS = 12;

  // Operation field on the issue port
  localparam int unsigned OP_BITS = 4;

  // ----------------------------------------
  // Operation encoding
  // ----------------------------------------

  // Numbering fixed at 0..11, the case file relies on it
  typedef enum logic [OP_BITS-1:0] {
    // ALU
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SLT,
    // Multiplier
    MUL,
    MULH,
    MULHU,
    // CSR buffer
    CSR_RW
  } fu_op_t;

endpackage

// File: verilog/fu_data_if.sv
// Operand bundle for one functional unit, driven by the execute stage and read by the unit
`timescale 1ns/1ps

interface fu_data_if
  import ex_pkg::*;
();

  // Decoded operation
  fu_op_t                     operation;
  // Source operands
  logic [XLEN-1:0]            operand_a;
  logic [XLEN-1:0]            operand_b;
  // Scoreboard slot to write back to
  logic [TRANS_ID_BITS-1:0]   trans_id;

  // Execute stage side
  modport issue (output operation, output operand_a, output operand_b, output trans_id);

  // Functional unit side
  modport unit (input operation, input operand_a, input operand_b, input trans_id);

endinterface

// File: verilog/ex_alu.sv
// Single-cycle integer ALU of the execute stage, purely combinational on its operand bundle
`timescale 1ns/1ps

module ex_alu
  import ex_pkg::*;
(
  fu_data_if.unit          fu,
  output logic [XLEN-1:0]  result_o
);

  // Shift amount, low 5 bits only
  logic [4:0]       shamt;
  // Signed compare for SLT
  logic             less_signed;
  logic [XLEN-1:0]  adder_sum;
  logic [XLEN-1:0]  adder_diff;

  assign shamt = fu.operand_b[4:0];

  // ----------------------------------------
  // Datapath
  // ----------------------------------------

  assign adder_sum  = fu.operand_a + fu.operand_b;
  assign adder_diff = fu.operand_a - fu.operand_b;

  // Both sides two's complement
  assign less_signed = $signed(fu.operand_a) < $signed(fu.operand_b);

  // ----------------------------------------
  // Result select
  // ----------------------------------------

  always_comb begin
    // Multiplier and CSR ops land here too
    result_o = '0;
    unique case (fu.operation)
      ADD: result_o = adder_sum;
      SUB: result_o = adder_diff;
      AND: result_o = fu.operand_a & fu.operand_b;
      OR:  result_o = fu.operand_a | fu.operand_b;
      XOR: result_o = fu.operand_a ^ fu.operand_b;
      // Logical shifts, zero fill
      SLL: result_o = fu.operand_a << shamt;
      SRL: result_o = fu.operand_a >> shamt;
      // Zero-extended compare flag
      SLT: result_o = {{(XLEN-1){1'b0}}, less_signed};
      default: result_o = '0;
    endcase
  end

  // Silenced bundle is op ADD with zero operands, so result is zero

endmodule

// File: verilog/ex_mult.sv
// One-cycle multiplier of the execute stage, result and transaction id registered one edge after issue
`timescale 1ns/1ps

module ex_mult
  import ex_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  logic                      mult_valid_i,
  fu_data_if.unit                   fu,
  output logic [XLEN-1:0]           result_o,
  output logic                      mult_valid_o,
  output logic [TRANS_ID_BITS-1:0]  mult_trans_id_o
);

  // Full-width products
  logic [2*XLEN-1:0]         prod_u;
  logic [2*XLEN-1:0]         prod_s;
  logic [XLEN-1:0]           result_d;
  // Pipeline register
  logic                      valid_q;
  logic [XLEN-1:0]           result_q;
  logic [TRANS_ID_BITS-1:0]  trans_id_q;

  // ----------------------------------------
  // Product and half select
  // ----------------------------------------

  // Zero-extended for MUL and MULHU
  assign prod_u = {{XLEN{1'b0}}, fu.operand_a} * {{XLEN{1'b0}}, fu.operand_b};

  // Sign-extended for MULH
  assign prod_s = $signed({{XLEN{fu.operand_a[XLEN-1]}}, fu.operand_a})
                * $signed({{XLEN{fu.operand_b[XLEN-1]}}, fu.operand_b});

  always_comb begin
    // Low half is the same for both signs
    result_d = prod_u[XLEN-1:0];
    if (fu.operation == MULH) begin
      result_d = prod_s[2*XLEN-1:XLEN];
    end else if (fu.operation == MULHU) begin
      result_d = prod_u[2*XLEN-1:XLEN];
    end
  end

  // ----------------------------------------
  // Output stage
  // ----------------------------------------

  // Flush together with issue drops the result
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= mult_valid_i & ~flush_i;
    end
  end

  // Payload only loads on issue
  always_ff @(posedge clk_i) begin
    if (mult_valid_i) begin
      result_q   <= result_d;
      trans_id_q <= fu.trans_id;
    end
  end

  // Flush in the result cycle kills it too
  assign mult_valid_o    = valid_q & ~flush_i;
  assign result_o        = result_q;
  assign mult_trans_id_o = trans_id_q;

endmodule

// File: verilog/ex_csr_buffer.sv
// Single-entry CSR address buffer of the execute stage, held until commit or flush and stalling issue
`timescale 1ns/1ps

module ex_csr_buffer
  import ex_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  logic                      csr_valid_i,
  input  logic                      csr_commit_i,
  fu_data_if.unit                   fu,
  output logic                      csr_ready_o,
  output logic [XLEN-1:0]           csr_result_o,
  output logic [CSR_ADDR_BITS-1:0]  csr_addr_o
);

  // Entry occupied
  logic                      valid_q;
  // Buffered CSR address
  logic [CSR_ADDR_BITS-1:0]  addr_q;

  // ----------------------------------------
  // Entry state
  // ----------------------------------------

  // Commit and flush both free the entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (csr_commit_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (csr_valid_i) begin
      valid_q <= 1'b1;
    end
  end

  // Address from low bits of operand_b, kept after free
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (csr_valid_i) begin
      addr_q <= fu.operand_b[CSR_ADDR_BITS-1:0];
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------

  // Blocks issue while full
  assign csr_ready_o  = ~valid_q;
  // Source value written back in the issue cycle
  assign csr_result_o = fu.operand_a;
  assign csr_addr_o   = addr_q;

endmodule

// File: verilog/ex_stage.sv
// Execute stage top level, fixed-latency ALU, multiplier and CSR buffer sharing one issue and write-back port
`timescale 1ns/1ps

module ex_stage
  import ex_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  // Per-unit issue strobes
  input  logic                      alu_valid_i,
  input  logic                      mult_valid_i,
  input  logic                      csr_valid_i,
  // Shared issue port
  input  logic [OP_BITS-1:0]        operation_i,
  input  logic [XLEN-1:0]           operand_a_i,
  input  logic [XLEN-1:0]           operand_b_i,
  input  logic [TRANS_ID_BITS-1:0]  trans_id_i,
  input  logic                      csr_commit_i,
  // Shared write-back port
  output logic [XLEN-1:0]           flu_result_o,
  output logic [TRANS_ID_BITS-1:0]  flu_trans_id_o,
  output logic                      flu_valid_o,
  output logic                      flu_ready_o,
  output logic [CSR_ADDR_BITS-1:0]  csr_addr_o
);

  logic [XLEN-1:0]           alu_result;
  logic [XLEN-1:0]           csr_result;
  logic [XLEN-1:0]           mult_result;
  logic                      mult_valid;
  logic [TRANS_ID_BITS-1:0]  mult_trans_id;
  fu_op_t                    operation;

  assign operation = fu_op_t'(operation_i);

  // ----------------------------------------
  // Operand silencing
  // ----------------------------------------

  fu_data_if alu_fu ();
  fu_data_if mult_fu ();
  fu_data_if csr_fu ();

  // Idle units see all zeros
  assign alu_fu.operation  = alu_valid_i ? operation : fu_op_t'('0);
  assign alu_fu.operand_a  = alu_valid_i ? operand_a_i : '0;
  assign alu_fu.operand_b  = alu_valid_i ? operand_b_i : '0;
  assign alu_fu.trans_id   = alu_valid_i ? trans_id_i : '0;

  assign mult_fu.operation = mult_valid_i ? operation : fu_op_t'('0);
  assign mult_fu.operand_a = mult_valid_i ? operand_a_i : '0;
  assign mult_fu.operand_b = mult_valid_i ? operand_b_i : '0;
  assign mult_fu.trans_id  = mult_valid_i ? trans_id_i : '0;

  assign csr_fu.operation  = csr_valid_i ? operation : fu_op_t'('0);
  assign csr_fu.operand_a  = csr_valid_i ? operand_a_i : '0;
  assign csr_fu.operand_b  = csr_valid_i ? operand_b_i : '0;
  assign csr_fu.trans_id   = csr_valid_i ? trans_id_i : '0;

  // ----------------------------------------
  // Functional units
  // ----------------------------------------

  // Zero latency
  ex_alu u_ex_alu (
    .fu       (alu_fu),
    .result_o (alu_result)
  );

  // One edge of latency
  ex_mult u_ex_mult (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .mult_valid_i    (mult_valid_i),
    .fu              (mult_fu),
    .result_o        (mult_result),
    .mult_valid_o    (mult_valid),
    .mult_trans_id_o (mult_trans_id)
  );

  // Result now, address held until commit
  ex_csr_buffer u_ex_csr_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .csr_valid_i  (csr_valid_i),
    .csr_commit_i (csr_commit_i),
    .fu           (csr_fu),
    .csr_ready_o  (flu_ready_o),
    .csr_result_o (csr_result),
    .csr_addr_o   (csr_addr_o)
  );

  // ----------------------------------------
  // Write-back merge
  // ----------------------------------------

  assign flu_valid_o = alu_valid_i | csr_valid_i | mult_valid;

  // Fixed priority, ALU then CSR then multiplier
  always_comb begin
    flu_result_o   = mult_result;
    flu_trans_id_o = trans_id_i;
    if (alu_valid_i) begin
      flu_result_o = alu_result;
    end else if (csr_valid_i) begin
      flu_result_o = csr_result;
    end else if (mult_valid) begin
      // Only the multiplier returns a delayed id
      flu_trans_id_o = mult_trans_id;
    end
  end

endmodule

// File: testbench/ex_stage_asserts.sv
// Protocol checks on the execute stage issue and write-back ports, bound into every ex_stage
`timescale 1ns/1ps

module ex_stage_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic flush_i,
  input logic alu_valid_i,
  input logic mult_valid_i,
  input logic csr_valid_i,
  input logic flu_valid_i,
  input logic flu_ready_i
);

  // Number of failed assertions so far
  int unsigned fail_count = 0;

  // CSR issue only into an empty buffer
  a_csr_issue_ready : assert property (
    @(posedge clk_i) disable iff (!rst_ni) csr_valid_i |-> flu_ready_i
  ) else begin
    $error("csr_valid_i raised while the CSR buffer is full");
    fail_count++;
  end

  // One issue strobe per cycle
  a_single_issue : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      $onehot0({alu_valid_i, mult_valid_i, csr_valid_i})
  ) else begin
    $error("More than one issue strobe high in the same cycle");
    fail_count++;
  end

  // Product shows up one edge later, unless a flush kills it there
  a_mult_writeback : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      mult_valid_i && !flush_i |=> flu_valid_i || flush_i
  ) else begin
    $error("Multiplier result missing one cycle after issue");
    fail_count++;
  end

endmodule

bind ex_stage ex_stage_asserts u_ex_stage_asserts (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .flush_i      (flush_i),
  .alu_valid_i  (alu_valid_i),
  .mult_valid_i (mult_valid_i),
  .csr_valid_i  (csr_valid_i),
  .flu_valid_i  (flu_valid_o),
  .flu_ready_i  (flu_ready_o)
);

// File: testbench/tb_ex_stage.sv
// Self-checking testbench for the execute stage, replays the case file and checks the write-back port
`timescale 1ns/1ps

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  // Sample point after the falling edge
  localparam int SETTLE = 10;
  localparam int FIELDS = 7;
  localparam int MAX_CASES = 64;
  localparam logic [31:0] SEED = 32'hcf81f52c;
  // Unit column codes
  localparam logic [31:0] UNIT_ALU = 32'h0;
  localparam logic [31:0] UNIT_MULT = 32'h1;
  localparam logic [31:0] UNIT_CSR = 32'h2;
  localparam logic [31:0] UNIT_FLUSH = 32'h3;
  // Column positions
  localparam int F_UNIT = 0;
  localparam int F_OP = 1;
  localparam int F_A = 2;
  localparam int F_B = 3;
  localparam int F_ID = 4;
  localparam int F_RES = 5;
  localparam int F_ADDR = 6;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      flush_i;
  logic                      alu_valid_i;
  logic                      mult_valid_i;
  logic                      csr_valid_i;
  logic [OP_BITS-1:0]        operation_i;
  logic [XLEN-1:0]           operand_a_i;
  logic [XLEN-1:0]           operand_b_i;
  logic [TRANS_ID_BITS-1:0]  trans_id_i;
  logic                      csr_commit_i;
  logic [XLEN-1:0]           flu_result_o;
  logic [TRANS_ID_BITS-1:0]  flu_trans_id_o;
  logic                      flu_valid_o;
  logic                      flu_ready_o;
  logic [CSR_ADDR_BITS-1:0]  csr_addr_o;

  logic [31:0] case_mem [0:FIELDS*MAX_CASES-1];
  int          num_cases;
  int          error_count;
  bit          cases_loaded = 1'b0;

  ex_stage u_ex_stage (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .alu_valid_i    (alu_valid_i),
    .mult_valid_i   (mult_valid_i),
    .csr_valid_i    (csr_valid_i),
    .operation_i    (operation_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .trans_id_i     (trans_id_i),
    .csr_commit_i   (csr_commit_i),
    .flu_result_o   (flu_result_o),
    .flu_trans_id_o (flu_trans_id_o),
    .flu_valid_o    (flu_valid_o),
    .flu_ready_o    (flu_ready_o),
    .csr_addr_o     (csr_addr_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  function automatic logic [31:0] case_field(int c, int k);
    return case_mem[c*FIELDS + k];
  endfunction

  task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    error_count++;
    $display("Error: %s expected %h got %h at %0t ns", name, expected, actual, $time);
  endtask

  task automatic drive_idle();
    alu_valid_i  = 1'b0;
    mult_valid_i = 1'b0;
    csr_valid_i  = 1'b0;
    flush_i      = 1'b0;
    csr_commit_i = 1'b0;
    operation_i  = '0;
    operand_a_i  = '0;
    operand_b_i  = '0;
    trans_id_i   = '0;
  endtask

  // Operation and operands of one case, strobe set by caller
  task automatic drive_case(int c);
    logic [31:0] op_word;
    logic [31:0] id_word;
    op_word = case_field(c, F_OP);
    id_word = case_field(c, F_ID);
    operation_i = op_word[OP_BITS-1:0];
    operand_a_i = case_field(c, F_A);
    operand_b_i = case_field(c, F_B);
    trans_id_i  = id_word[TRANS_ID_BITS-1:0];
  endtask

  task automatic check_writeback(int c);
    logic [31:0] id_word;
    id_word = case_field(c, F_ID);
    if (flu_valid_o !== 1'b1)
      report_mismatch("flu_valid_o", 32'h1, 32'(flu_valid_o));
    if (flu_result_o !== case_field(c, F_RES))
      report_mismatch("flu_result_o", case_field(c, F_RES), flu_result_o);
    if (flu_trans_id_o !== id_word[TRANS_ID_BITS-1:0])
      report_mismatch("flu_trans_id_o", 32'(id_word[TRANS_ID_BITS-1:0]), 32'(flu_trans_id_o));
  endtask

  task automatic load_cases();
    $readmemh("testbench/ex_cases.txt", case_mem);
    num_cases = 0;
    // Stops at the end marker line
    while (num_cases < MAX_CASES && case_field(num_cases, F_UNIT) <= UNIT_FLUSH)
      num_cases++;
    if (num_cases == 0) begin
      error_count++;
      $display("No test cases were read from the case file");
    end
    cases_loaded = 1'b1;
  endtask

  // ----------------------------------------
  // Per-unit sequences, entered and left on a falling edge
  // ----------------------------------------

  // Zero latency, checked in the issue cycle
  task automatic run_alu(int c);
    drive_case(c);
    alu_valid_i = 1'b1;
    #SETTLE;
    check_writeback(c);
    @(negedge clk_i);
    drive_idle();
  endtask

  // Consecutive mult lines issue back to back
  task automatic run_mult(inout int c);
    drive_case(c);
    mult_valid_i = 1'b1;
    @(negedge clk_i);
    while (c + 1 < num_cases && case_field(c + 1, F_UNIT) == UNIT_MULT) begin
      drive_case(c + 1);
      #SETTLE;
      check_writeback(c);
      c++;
      @(negedge clk_i);
    end
    drive_idle();
    #SETTLE;
    check_writeback(c);
    // Port stays idle in the result cycle
    @(negedge clk_i);
  endtask

  task automatic run_csr(int c, bit use_flush);
    logic [31:0] addr_word;
    int unsigned wait_cycles;
    addr_word = case_field(c, F_ADDR);
    drive_case(c);
    csr_valid_i = 1'b1;
    #SETTLE;
    check_writeback(c);
    @(negedge clk_i);
    drive_idle();
    #SETTLE;
    if (csr_addr_o !== addr_word[CSR_ADDR_BITS-1:0])
      report_mismatch("csr_addr_o", 32'(addr_word[CSR_ADDR_BITS-1:0]), 32'(csr_addr_o));
    if (flu_ready_o !== 1'b0)
      report_mismatch("flu_ready_o", 32'h0, 32'(flu_ready_o));
    // Commit or flush arrives some cycles later
    wait_cycles = $urandom_range(2, 0);
    @(negedge clk_i);
    repeat (wait_cycles) @(negedge clk_i);
    if (use_flush)
      flush_i = 1'b1;
    else
      csr_commit_i = 1'b1;
    @(negedge clk_i);
    drive_idle();
    #SETTLE;
    if (flu_ready_o !== 1'b1)
      report_mismatch("flu_ready_o", 32'h1, 32'(flu_ready_o));
    @(negedge clk_i);
  endtask

  // Flush right after issue, no write-back at all
  task automatic run_mult_flush(int c);
    drive_case(c);
    mult_valid_i = 1'b1;
    @(negedge clk_i);
    drive_idle();
    flush_i = 1'b1;
    #SETTLE;
    if (flu_valid_o !== 1'b0)
      report_mismatch("flu_valid_o", 32'h0, 32'(flu_valid_o));
    @(negedge clk_i);
    flush_i = 1'b0;
    #SETTLE;
    if (flu_valid_o !== 1'b0)
      report_mismatch("flu_valid_o", 32'h0, 32'(flu_valid_o));
    @(negedge clk_i);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    int          idx;
    int unsigned gap;
    int unsigned assert_failures;
    logic [31:0] unit_word;
    logic [31:0] op_word;
    void'($urandom(SEED));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    error_count = 0;
    drive_idle();
    load_cases();
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    #SETTLE;
    // Idle state out of reset
    if (flu_valid_o !== 1'b0)
      report_mismatch("flu_valid_o", 32'h0, 32'(flu_valid_o));
    if (flu_ready_o !== 1'b1)
      report_mismatch("flu_ready_o", 32'h1, 32'(flu_ready_o));
    if (csr_addr_o !== '0)
      report_mismatch("csr_addr_o", 32'h0, 32'(csr_addr_o));
    @(negedge clk_i);
    idx = 0;
    while (idx < num_cases) begin
      unit_word = case_field(idx, F_UNIT);
      op_word = case_field(idx, F_OP);
      if (unit_word == UNIT_ALU)
        run_alu(idx);
      else if (unit_word == UNIT_MULT)
        run_mult(idx);
      else if (unit_word == UNIT_CSR)
        run_csr(idx, 1'b0);
      else if (fu_op_t'(op_word[OP_BITS-1:0]) == CSR_RW)
        run_csr(idx, 1'b1);
      else
        run_mult_flush(idx);
      idx++;
      gap = $urandom_range(2, 0);
      repeat (gap) @(negedge clk_i);
    end
    assert_failures = u_ex_stage.u_ex_stage_asserts.fail_count;
    $display("Summary: %0d cases, %0d check errors, %0d assertion failures",
             num_cases, error_count, assert_failures);
    if (error_count == 0 && assert_failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog, six cycles per case plus reset margin
  initial begin
    int timeout_cycles;
    wait (cases_loaded);
    timeout_cycles = num_cases * 6 + 10;
    #(timeout_cycles * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: src.f
verilog/ex_pkg.sv
verilog/fu_data_if.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_csr_buffer.sv
verilog/ex_stage.sv
testbench/ex_stage_asserts.sv
testbench/tb_ex_stage.sv

// File: run.sh
#!/bin/sh
# Build the execute stage testbench with Verilator, run it, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_ex_stage
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module tb_ex_stage -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation finished: PASS" "$LOG"; then
  exit 0
else
  echo "Pass line not found in $LOG"
  exit 1
fi

// File: testbench/ex_cases.txt
// unit (0 alu, 1 mult, 2 csr, 3 flush test, f ends list), op (0 ADD .. b CSR_RW), operand_a,
// operand_b, trans_id, expected result, expected csr address; every column in hex
0 0 7fffffff 00000001 1 80000000 000
0 1 00000005 00000007 2 fffffffe 000
0 2 f0f0f0f0 ff00ff00 3 f000f000 000
0 3 f0f0f0f0 0f0f0000 4 fffff0f0 000
0 4 aaaa5555 ffff0000 5 55555555 000
0 5 00000003 00000021 6 00000006 000
0 6 80000000 00000024 7 08000000 000
0 7 fffffffb 00000003 0 00000001 000
0 7 00000005 fffffffd 1 00000000 000
0 5 12345678 00000020 2 12345678 000
1 8 00000003 00000005 3 0000000f 000
1 8 0000ffff 0000ffff 4 fffe0001 000
1 8 ffffffff 00000002 5 fffffffe 000
2 b deadbeef 00012345 6 deadbeef 345
1 9 80000000 00000002 7 ffffffff 000
1 a ffffffff ffffffff 0 fffffffe 000
1 9 ffffffff ffffffff 1 00000000 000
2 b 00000042 fffff300 2 00000042 300
3 8 00000006 00000007 3 00000000 000
3 b 12345678 00000c00 4 12345678 c00
0 0 00000001 00000002 5 00000003 000
f 0 00000000 00000000 0 00000000 000
